// ==== Makefile ====
# Verilator build and run for the CSR unit testbench

VERILATOR ?= verilator
TOP       ?= csr_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Verification passed" $(LOG) && echo "PASS" || (echo "FAIL: see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
hw/csr_pkg.sv
hw/csr_op_unit.sv
hw/cycle_counter.sv
hw/trap_ctrl.sv
hw/csr_regfile.sv
hw/csr_top.sv
test/csr_properties.sv
test/csr_tb.sv

// ==== hw/csr_op_unit.sv ====
// Pure combinational; a set or clear with zero operand on a 0xCxx/0xFxx address is a plain read
module csr_op_unit (
  input  logic               csr_valid,
  input  csr_pkg::csr_op_e   csr_op,
  input  csr_pkg::csr_addr_t csr_addr,
  input  csr_pkg::xlen_t     old_value,
  input  csr_pkg::xlen_t     operand,
  output csr_pkg::xlen_t     new_value,
  output logic               wr_en
);

  logic read_only;
  logic no_write;

  always_comb begin
    case (csr_op)
      csr_pkg::op_rw: new_value = operand;
      csr_pkg::op_rs: new_value = old_value | operand;
      csr_pkg::op_rc: new_value = old_value & ~operand;
      default:        new_value = old_value; // Reserved encoding leaves the value alone
    endcase
  end

  // Address bits 11:10 = 2'b11 is the read-only CSR space
  assign read_only = (csr_addr[11:10] == 2'b11);

  // CSRRS/CSRRC with rs1 = x0 must not count as a write
  assign no_write = (csr_op != csr_pkg::op_rw) && (operand == '0) && read_only;

  assign wr_en = csr_valid && !no_write;

endmodule

// ==== hw/csr_pkg.sv ====
// Machine-mode only RV64I CSR definitions; S and U modes, vectored mtvec and other counters absent
package csr_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [11:0] csr_addr_t;

  // Encodings follow funct3[1:0] of CSRRW, CSRRS, CSRRC
  typedef enum logic [1:0] {
    op_rw = 2'b01,
    op_rs = 2'b10,
    op_rc = 2'b11
  } csr_op_e;

  // One word, two views: raw for masking, fields for trap entry and mret
  typedef union packed {
    xlen_t raw;
    struct packed {
      logic        sd;
      logic [49:0] rsv_62_13;
      logic [1:0]  mpp;
      logic [2:0]  rsv_10_8;
      logic        mpie;
      logic [2:0]  rsv_6_4;
      logic        mie;
      logic [2:0]  rsv_2_0;
    } f;
  } mstatus_u;

  localparam csr_addr_t addr_mstatus   = 12'h300;
  localparam csr_addr_t addr_misa      = 12'h301;
  localparam csr_addr_t addr_mie       = 12'h304;
  localparam csr_addr_t addr_mtvec     = 12'h305;
  localparam csr_addr_t addr_mscratch  = 12'h340;
  localparam csr_addr_t addr_mepc      = 12'h341;
  localparam csr_addr_t addr_mcause    = 12'h342;
  localparam csr_addr_t addr_mtval     = 12'h343;
  localparam csr_addr_t addr_mip       = 12'h344;
  localparam csr_addr_t addr_mcycle    = 12'hb00;
  localparam csr_addr_t addr_mvendorid = 12'hf11;
  localparam csr_addr_t addr_marchid   = 12'hf12;
  localparam csr_addr_t addr_mimpid    = 12'hf13;
  localparam csr_addr_t addr_mhartid   = 12'hf14;

  localparam xlen_t mstatus_wmask   = 64'h0000_0000_0000_1888; // mpp, mpie, mie
  localparam xlen_t mie_wmask       = 64'h0000_0000_0000_0888; // msie, mtie, meie
  localparam xlen_t misa_value      = 64'h8000_0000_0000_0100; // MXL=2, I only
  localparam xlen_t mstatus_reset   = 64'h0000_0000_0000_1800; // mpp = M
  localparam xlen_t cause_timer_irq = 64'h8000_0000_0000_0007;

endpackage

// ==== hw/csr_regfile.sv ====
// Machine CSRs only; misa and ID registers are constants, mip.MTIP mirrors irq_timer with no delay
module csr_regfile #(
  parameter csr_pkg::xlen_t RESET_PC = 64'h0000_0000_8000_0000
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               irq_timer,
  input  csr_pkg::csr_addr_t rd_addr,
  output csr_pkg::xlen_t     rd_data,
  output logic               illegal,
  input  logic               wr_en,
  input  csr_pkg::xlen_t     wr_data,
  input  logic               trap_we,
  input  logic               mret_we,
  input  csr_pkg::mstatus_u  trap_mstatus,
  input  csr_pkg::xlen_t     trap_mepc,
  input  csr_pkg::xlen_t     trap_mcause,
  input  csr_pkg::xlen_t     trap_mtval,
  input  csr_pkg::xlen_t     mcycle,
  output logic               mcycle_we,
  output csr_pkg::mstatus_u  mstatus,
  output csr_pkg::xlen_t     mie,
  output csr_pkg::xlen_t     mip,
  output csr_pkg::xlen_t     mtvec,
  output csr_pkg::xlen_t     mepc
);

  csr_pkg::mstatus_u mstatus_q;
  csr_pkg::xlen_t    mie_q;
  csr_pkg::xlen_t    mtvec_q;
  csr_pkg::xlen_t    mscratch_q;
  csr_pkg::xlen_t    mepc_q;
  csr_pkg::xlen_t    mcause_q;
  csr_pkg::xlen_t    mtval_q;
  logic              known;
  logic              csr_we; // Software write, blocked while a trap commits

  assign csr_we    = wr_en && !trap_we;
  assign mcycle_we = csr_we && (rd_addr == csr_pkg::addr_mcycle);

  // mpp is forced to M on every write path
  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q.raw <= csr_pkg::mstatus_reset;
    end else if (trap_we || mret_we) begin
      mstatus_q.raw <= (trap_mstatus.raw & csr_pkg::mstatus_wmask) | csr_pkg::mstatus_reset;
    end else if (csr_we && rd_addr == csr_pkg::addr_mstatus) begin
      mstatus_q.raw <= (wr_data & csr_pkg::mstatus_wmask) | csr_pkg::mstatus_reset;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mie_q      <= '0;
      mtvec_q    <= {RESET_PC[63:2], 2'b00};
      mscratch_q <= '0;
    end else if (csr_we) begin
      if (rd_addr == csr_pkg::addr_mie) mie_q <= wr_data & csr_pkg::mie_wmask;
      if (rd_addr == csr_pkg::addr_mtvec) mtvec_q <= {wr_data[63:2], 2'b00}; // Direct mode
      if (rd_addr == csr_pkg::addr_mscratch) mscratch_q <= wr_data;
    end
  end

  // Trap entry overrides any software write to these
  always_ff @(posedge clk) begin
    if (rst) begin
      mepc_q   <= '0;
      mcause_q <= '0;
      mtval_q  <= '0;
    end else if (trap_we) begin
      mepc_q   <= {trap_mepc[63:2], 2'b00};
      mcause_q <= trap_mcause;
      mtval_q  <= trap_mtval;
    end else if (csr_we) begin
      if (rd_addr == csr_pkg::addr_mepc) mepc_q <= {wr_data[63:2], 2'b00};
      if (rd_addr == csr_pkg::addr_mcause) mcause_q <= wr_data;
      if (rd_addr == csr_pkg::addr_mtval) mtval_q <= wr_data;
    end
  end

  assign mip = {56'd0, irq_timer, 7'd0}; // MTIP only, not software writable

  // Read returns the value before this cycle's write
  always_comb begin
    rd_data = '0;
    known   = 1'b1;
    case (rd_addr)
      csr_pkg::addr_mstatus:  rd_data = mstatus_q.raw;
      csr_pkg::addr_misa:     rd_data = csr_pkg::misa_value;
      csr_pkg::addr_mie:      rd_data = mie_q;
      csr_pkg::addr_mtvec:    rd_data = mtvec_q;
      csr_pkg::addr_mscratch: rd_data = mscratch_q;
      csr_pkg::addr_mepc:     rd_data = mepc_q;
      csr_pkg::addr_mcause:   rd_data = mcause_q;
      csr_pkg::addr_mtval:    rd_data = mtval_q;
      csr_pkg::addr_mip:      rd_data = mip;
      csr_pkg::addr_mcycle:   rd_data = mcycle;
      csr_pkg::addr_mvendorid,
      csr_pkg::addr_marchid,
      csr_pkg::addr_mimpid,
      csr_pkg::addr_mhartid:  rd_data = '0; // ID registers read as zero
      default:                known   = 1'b0;
    endcase
  end

  assign illegal = !known || (wr_en && rd_addr[11:10] == 2'b11);

  assign mstatus = mstatus_q;
  assign mie     = mie_q;
  assign mtvec   = mtvec_q;
  assign mepc    = mepc_q;

endmodule

// ==== hw/csr_top.sv ====
// Single hart, M mode only; all requests are one-cycle strobes and must not arrive while busy
module csr_top #(
  parameter csr_pkg::xlen_t RESET_PC = 64'h0000_0000_8000_0000
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               csr_valid,
  input  csr_pkg::csr_op_e   csr_op,
  input  csr_pkg::csr_addr_t csr_addr,
  input  csr_pkg::xlen_t     csr_operand,
  input  logic               exc_valid,
  input  csr_pkg::xlen_t     exc_cause,
  input  csr_pkg::xlen_t     exc_pc,
  input  csr_pkg::xlen_t     exc_tval,
  input  logic               mret_valid,
  input  csr_pkg::xlen_t     cur_pc,
  input  logic               irq_timer,
  output csr_pkg::xlen_t     csr_rdata,
  output logic               csr_illegal,
  output logic               redirect_valid,
  output csr_pkg::xlen_t     redirect_pc,
  output logic               busy
);

  csr_pkg::xlen_t    old_value;
  csr_pkg::xlen_t    new_value;
  logic              wr_en;
  logic              rf_illegal;
  csr_pkg::xlen_t    mcycle;
  logic              mcycle_we;
  csr_pkg::mstatus_u mstatus;
  csr_pkg::xlen_t    mie;
  csr_pkg::xlen_t    mip;
  csr_pkg::xlen_t    mtvec;
  csr_pkg::xlen_t    mepc;
  logic              trap_we;
  logic              mret_we;
  csr_pkg::mstatus_u new_mstatus;
  csr_pkg::xlen_t    new_mepc;
  csr_pkg::xlen_t    new_mcause;
  csr_pkg::xlen_t    new_mtval;

  // Read port is only meaningful with an instruction present
  assign csr_rdata   = csr_valid ? old_value : '0;
  assign csr_illegal = csr_valid && rf_illegal;

  csr_regfile #(.RESET_PC(RESET_PC)) u_regfile (
    .clk(clk), .rst(rst), .irq_timer(irq_timer),
    .rd_addr(csr_addr), .rd_data(old_value), .illegal(rf_illegal),
    .wr_en(wr_en), .wr_data(new_value),
    .trap_we(trap_we), .mret_we(mret_we), .trap_mstatus(new_mstatus),
    .trap_mepc(new_mepc), .trap_mcause(new_mcause), .trap_mtval(new_mtval),
    .mcycle(mcycle), .mcycle_we(mcycle_we),
    .mstatus(mstatus), .mie(mie), .mip(mip), .mtvec(mtvec), .mepc(mepc)
  );

  csr_op_unit u_op (
    .csr_valid(csr_valid), .csr_op(csr_op), .csr_addr(csr_addr),
    .old_value(old_value), .operand(csr_operand),
    .new_value(new_value), .wr_en(wr_en)
  );

  cycle_counter u_mcycle (
    .clk(clk), .rst(rst), .load(mcycle_we), .load_value(new_value), .count(mcycle)
  );

  trap_ctrl u_trap (
    .clk(clk), .rst(rst),
    .exc_valid(exc_valid), .exc_cause(exc_cause), .exc_pc(exc_pc), .exc_tval(exc_tval),
    .mret_valid(mret_valid), .cur_pc(cur_pc),
    .mstatus(mstatus), .mie(mie), .mip(mip), .mtvec(mtvec), .mepc(mepc),
    .trap_we(trap_we), .mret_we(mret_we), .new_mstatus(new_mstatus),
    .new_mepc(new_mepc), .new_mcause(new_mcause), .new_mtval(new_mtval),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc), .busy(busy)
  );

endmodule

// ==== hw/cycle_counter.sv ====
// Free-running 64-bit mcycle; a software load replaces the increment in that cycle
module cycle_counter (
  input  logic           clk,
  input  logic           rst,
  input  logic           load,
  input  csr_pkg::xlen_t load_value,
  output csr_pkg::xlen_t count
);

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (load) begin
      count <= load_value; // Read back next cycle as the written value
    end else begin
      count <= count + 64'd1;
    end
  end

endmodule

// ==== hw/trap_ctrl.sv ====
// Timer interrupt only, direct mtvec mode; events are ignored while busy
module trap_ctrl (
  input  logic              clk,
  input  logic              rst,
  input  logic              exc_valid,
  input  csr_pkg::xlen_t    exc_cause,
  input  csr_pkg::xlen_t    exc_pc,
  input  csr_pkg::xlen_t    exc_tval,
  input  logic              mret_valid,
  input  csr_pkg::xlen_t    cur_pc,
  input  csr_pkg::mstatus_u mstatus,
  input  csr_pkg::xlen_t    mie,
  input  csr_pkg::xlen_t    mip,
  input  csr_pkg::xlen_t    mtvec,
  input  csr_pkg::xlen_t    mepc,
  output logic              trap_we,
  output logic              mret_we,
  output csr_pkg::mstatus_u new_mstatus,
  output csr_pkg::xlen_t    new_mepc,
  output csr_pkg::xlen_t    new_mcause,
  output csr_pkg::xlen_t    new_mtval,
  output logic              redirect_valid,
  output csr_pkg::xlen_t    redirect_pc,
  output logic              busy
);

  localparam logic [1:0] RUN   = 2'd0;
  localparam logic [1:0] ENTER = 2'd1;
  localparam logic [1:0] EXIT  = 2'd2;

  logic [1:0]     state;
  logic [1:0]     state_nxt;
  logic           irq_take;
  csr_pkg::xlen_t cause_q;
  csr_pkg::xlen_t epc_q;
  csr_pkg::xlen_t tval_q;

  // Global enable, MTIE and MTIP all needed
  assign irq_take = mstatus.f.mie && mie[7] && mip[7];

  always_comb begin
    state_nxt = RUN;
    if (state == RUN) begin
      if (exc_valid || irq_take) begin
        state_nxt = ENTER;
      end else if (mret_valid) begin
        state_nxt = EXIT;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= RUN;
    end else begin
      state <= state_nxt;
    end
  end

  // Trap payload captured in the event cycle, exception first
  always_ff @(posedge clk) begin
    if (state == RUN && exc_valid) begin
      cause_q <= exc_cause;
      epc_q   <= exc_pc;
      tval_q  <= exc_tval;
    end else if (state == RUN && irq_take) begin
      cause_q <= csr_pkg::cause_timer_irq;
      epc_q   <= cur_pc;
      tval_q  <= '0;
    end
  end

  always_comb begin
    new_mstatus = mstatus;
    if (state == EXIT) begin
      new_mstatus.f.mie  = mstatus.f.mpie;
      new_mstatus.f.mpie = 1'b1;
    end else begin
      new_mstatus.f.mpie = mstatus.f.mie; // Stack the enable on entry
      new_mstatus.f.mie  = 1'b0;
    end
    new_mstatus.f.mpp = 2'b11; // Only M mode exists
  end

  assign trap_we        = (state == ENTER);
  assign mret_we        = (state == EXIT);
  assign busy           = (state != RUN);
  assign redirect_valid = busy;
  assign redirect_pc    = (state == EXIT) ? mepc : mtvec;
  assign new_mepc       = epc_q;
  assign new_mcause     = cause_q;
  assign new_mtval      = tval_q;

endmodule

// ==== test/csr_golden.txt ====
# kind op addr operand_or_pc cause tval expected (hex); csr: cause = expected csr_illegal,
# tval 1 skips the rdata check; exc, irq, mret: expected = redirect_pc
csr 2 301 0 0 0 8000000000000100
csr 2 300 0 0 0 1800
csr 2 305 0 0 0 80001000
csr 1 340 deadbeefcafef00d 0 0 0
csr 2 340 f0 0 0 deadbeefcafef00d
csr 3 340 ffff000000000000 0 0 deadbeefcafef0fd
csr 1 304 ffffffffffffffff 0 0 0
csr 3 304 8 0 0 888
csr 1 300 ffffffffffffffff 0 0 1800
csr 3 300 80 0 0 1888
csr 2 7c0 0 1 0 0
csr 1 f14 5 1 0 0
exc 0 0 80000404 2 deadc0de 80001000
csr 2 341 0 0 0 80000404
csr 2 342 0 0 0 2
csr 2 343 0 0 0 deadc0de
csr 2 300 0 0 0 1880
mret 0 0 0 0 0 80000404
csr 2 300 0 0 0 1888
irq 0 0 80000200 0 0 80001000
csr 2 342 0 0 0 8000000000000007
csr 2 341 0 0 0 80000200
csr 1 b00 1000 0 1 0
csr 2 340 0 0 0 0000beefcafef0fd
csr 2 304 0 0 0 880
csr 2 b00 0 0 0 1002

// ==== test/csr_properties.sv ====
// Bound into csr_top; an event means any exc_valid, mret_valid or irq_timer seen since reset
module csr_properties (
  input logic           clk,
  input logic           rst,
  input logic           csr_valid,
  input csr_pkg::xlen_t csr_rdata,
  input logic           exc_valid,
  input logic           mret_valid,
  input logic           irq_timer,
  input logic           redirect_valid,
  input logic           busy
);

  logic event_seen;

  always_ff @(posedge clk) begin
    if (rst) begin
      event_seen <= 1'b0;
    end else if (exc_valid || mret_valid || irq_timer) begin
      event_seen <= 1'b1;
    end
  end

  redirect_one_cycle: assert property (@(posedge clk) disable iff (rst)
    redirect_valid |=> !redirect_valid) else $error("redirect_valid wider than one cycle");

  // Busy only in the redirect cycle that follows an event strobe
  busy_is_redirect: assert property (@(posedge clk) disable iff (rst)
    busy |-> redirect_valid && $past(exc_valid || mret_valid || irq_timer))
    else $error("busy without a redirect right after an event");

  rdata_zero_idle: assert property (@(posedge clk) disable iff (rst)
    !csr_valid |-> csr_rdata == '0) else $error("csr_rdata nonzero without csr_valid");

  no_early_redirect: assert property (@(posedge clk) disable iff (rst)
    !event_seen |-> !redirect_valid) else $error("redirect before any event");

endmodule

bind csr_top csr_properties props0 (
  .clk(clk), .rst(rst), .csr_valid(csr_valid), .csr_rdata(csr_rdata),
  .exc_valid(exc_valid), .mret_valid(mret_valid), .irq_timer(irq_timer),
  .redirect_valid(redirect_valid), .busy(busy)
);

// ==== test/csr_tb.sv ====
// Reads test/csr_golden.txt relative to the project root; RESET_PC is 0x8000_1000 to match it
module csr_tb;

  localparam csr_pkg::xlen_t reset_pc = 64'h0000_0000_8000_1000;

  logic               clk;
  logic               rst;
  logic               csr_valid;
  csr_pkg::csr_op_e   csr_op;
  csr_pkg::csr_addr_t csr_addr;
  csr_pkg::xlen_t     csr_operand;
  logic               exc_valid;
  csr_pkg::xlen_t     exc_cause;
  csr_pkg::xlen_t     exc_pc;
  csr_pkg::xlen_t     exc_tval;
  logic               mret_valid;
  csr_pkg::xlen_t     cur_pc;
  logic               irq_timer;
  csr_pkg::xlen_t     csr_rdata;
  logic               csr_illegal;
  logic               redirect_valid;
  csr_pkg::xlen_t     redirect_pc;
  logic               busy;

  integer seed    = 32'h5672514c;
  int     errors  = 0;
  int     checks  = 0;
  int     n_tests = 0;
  bit     loaded  = 1'b0;

  // One entry per golden record
  logic [31:0]        kind_q[$];
  logic [1:0]         op_q[$];
  csr_pkg::csr_addr_t addr_q[$];
  csr_pkg::xlen_t     val_q[$];
  csr_pkg::xlen_t     cause_q[$];
  csr_pkg::xlen_t     tval_q[$];
  csr_pkg::xlen_t     exp_q[$];

  csr_top #(.RESET_PC(reset_pc)) dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_value(input string name, input csr_pkg::xlen_t actual,
                             input csr_pkg::xlen_t expected);
    checks++;
    if (actual !== expected) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
      errors++;
    end
  endtask

  // Strobes low, unused operand fields filled with noise
  task automatic drive_idle();
    csr_valid   = 1'b0;
    exc_valid   = 1'b0;
    mret_valid  = 1'b0;
    csr_operand = {$random(seed), $random(seed)};
    exc_cause   = {$random(seed), $random(seed)};
    exc_pc      = {$random(seed), $random(seed)};
    exc_tval    = {$random(seed), $random(seed)};
  endtask

  // Event strobe was driven in this cycle; redirect must follow one cycle later
  task automatic wait_redirect(input csr_pkg::xlen_t exp_pc);
    int cycles;
    cycles = 0;
    while (!redirect_valid && cycles < 4) begin
      @(posedge clk);
      #1;
      exc_valid  = 1'b0;
      mret_valid = 1'b0;
      cycles++;
    end
    if (cycles != 1) begin
      $display("Redirect came %0d cycles after the event instead of one", cycles);
      errors++;
    end
    check_value("busy", {63'd0, busy}, 64'd1);
    check_value("redirect_pc", redirect_pc, exp_pc);
  endtask

  task automatic run_record(input int i);
    int err_before;
    err_before = errors;
    @(posedge clk);
    #1;
    drive_idle();
    if (kind_q[i] == {8'h00, "csr"}) begin
      csr_valid   = 1'b1;
      csr_op      = csr_pkg::csr_op_e'(op_q[i]);
      csr_addr    = addr_q[i];
      csr_operand = val_q[i];
      #8;
      check_value("busy", {63'd0, busy}, 64'd0);
      check_value("csr_illegal", {63'd0, csr_illegal}, cause_q[i]);
      if (tval_q[i] == '0) check_value("csr_rdata", csr_rdata, exp_q[i]);
    end else if (kind_q[i] == {8'h00, "exc"}) begin
      exc_valid = 1'b1;
      exc_pc    = val_q[i];
      exc_cause = cause_q[i];
      exc_tval  = tval_q[i];
      wait_redirect(exp_q[i]);
    end else if (kind_q[i] == "mret") begin
      mret_valid = 1'b1;
      wait_redirect(exp_q[i]);
    end else if (kind_q[i] == {8'h00, "irq"}) begin
      cur_pc    = val_q[i];
      irq_timer = 1'b1;
      wait_redirect(exp_q[i]);
      irq_timer = 1'b0; // MIE clears as the trap commits, no retake
    end else begin
      $display("Test %0d has an unknown record kind", i);
      errors++;
    end
    $display("Test %0d: %s", i, (errors == err_before) ? "ok" : "mismatch");
  endtask

  initial begin
    int                 fd;
    int                 n;
    string              line;
    logic [31:0]        kind;
    logic [1:0]         op;
    csr_pkg::csr_addr_t addr;
    csr_pkg::xlen_t     val;
    csr_pkg::xlen_t     cause;
    csr_pkg::xlen_t     tval;
    csr_pkg::xlen_t     expv;
    rst       = 1'b1;
    irq_timer = 1'b0;
    cur_pc    = '0;
    csr_op    = csr_pkg::op_rw;
    csr_addr  = '0;
    drive_idle();
    fd = $fopen("test/csr_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open test/csr_golden.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.getc(0) != "#") begin
          n = $sscanf(line, "%s %h %h %h %h %h %h", kind, op, addr, val, cause, tval, expv);
          if (n == 7) begin
            kind_q.push_back(kind);
            op_q.push_back(op);
            addr_q.push_back(addr);
            val_q.push_back(val);
            cause_q.push_back(cause);
            tval_q.push_back(tval);
            exp_q.push_back(expv);
          end
        end
      end
      $fclose(fd);
    end
    n_tests = kind_q.size();
    if (n_tests == 0) begin
      $display("No test records were read");
      errors++;
    end
    loaded = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < n_tests; i++) begin
      run_record(i);
    end
    @(posedge clk);
    #1;
    drive_idle();
    $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Budget of 20 cycles per record plus reset
  initial begin
    wait (loaded);
    #((n_tests * 20 + 20) * 20);
    $display("Timeout: the run did not finish within its cycle budget");
    $display("Verification failed");
    $finish;
  end

endmodule
